/* forth_core.f */
+incdir+verif
verilog/forth_pkg.sv
verilog/stack_io.sv
verilog/lifo_stack.sv
verilog/exec_unit.sv
verilog/forth_core.sv
verif/forth_core_tb.sv

/* verif/forth_vectors.svh */
/*
 * forth core vector table
 * one opcode per row with the state expected just after its edge
 */
`ifndef FORTH_VECTORS_SVH
`define FORTH_VECTORS_SVH

// expected fields hold the visible state once the row's edge has passed
typedef struct packed {
    logic               en;
    opcode_e            op;
    logic [CELL_W-1:0]  lit;
    logic [CELL_W-1:0]  tos;
    logic [CELL_W-1:0]  nos;
    logic [ADDR_W-1:0]  ip;
    logic [DEPTH_W-1:0] ds_depth;
    logic [DEPTH_W-1:0] rs_depth;
    logic [CELL_W-1:0]  rs_top;
    logic               ds_err;
} row_t;

localparam int N_ROWS = 66;

// en, op, lit | tos, nos, ip, ds_depth, rs_depth, rs_top, ds_err
localparam row_t VECTORS [N_ROWS] = '{
    // literals and shuffles
    '{1'b1, OP_DOLIT,   32'h5, 32'h5, 32'h0, 17'h101, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h7, 32'h7, 32'h5, 17'h102, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_OVER,    32'h0, 32'h5, 32'h7, 17'h103, 5'd3, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_SWAP,    32'h0, 32'h7, 32'h5, 17'h104, 5'd3, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DUP,     32'h0, 32'h7, 32'h7, 17'h105, 5'd4, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h7, 32'h5, 17'h106, 5'd3, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h5, 32'h5, 17'h107, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h5, 32'h0, 17'h108, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h0, 32'h0, 17'h109, 5'd0, 5'd0, 32'h0, 1'b0},
    // arithmetic, -3 + 10 then on from there
    '{1'b1, OP_DOLIT,   32'hFFFFFFFD, 32'hFFFFFFFD, 32'h0, 17'h10a, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'hA, 32'hA, 32'hFFFFFFFD, 17'h10b, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ADD,     32'h0, 32'h7, 32'h0, 17'h10c, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h9, 32'h9, 32'h7, 17'h10d, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_SUB,     32'h0, 32'hFFFFFFFE, 32'h0, 17'h10e, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h6, 32'h6, 32'hFFFFFFFE, 17'h10f, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_MUL,     32'h0, 32'hFFFFFFF4, 32'h0, 17'h110, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h0F0F00FF, 32'h0F0F00FF, 32'hFFFFFFF4, 17'h111, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_AND,     32'h0, 32'h0F0F00F4, 32'h0, 17'h112, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h30000003, 32'h30000003, 32'h0F0F00F4, 17'h113, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_OR,      32'h0, 32'h3F0F00F7, 32'h0, 17'h114, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'hFFFF, 32'hFFFF, 32'h3F0F00F7, 17'h115, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_XOR,     32'h0, 32'h3F0FFF08, 32'h0, 17'h116, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_NEGATE,  32'h0, 32'hC0F000F8, 32'h0, 17'h117, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ABS,     32'h0, 32'h3F0FFF08, 32'h0, 17'h118, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_INVERT,  32'h0, 32'hC0F000F7, 32'h0, 17'h119, 5'd1, 5'd0, 32'h0, 1'b0},
    // max / min differ from an unsigned reading
    '{1'b1, OP_DOLIT,   32'h5, 32'h5, 32'hC0F000F7, 17'h11a, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_MAX,     32'h0, 32'h5, 32'h0, 17'h11b, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'hFFFFFFF0, 32'hFFFFFFF0, 32'h5, 17'h11c, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_MIN,     32'h0, 32'hFFFFFFF0, 32'h0, 17'h11d, 5'd1, 5'd0, 32'h0, 1'b0},
    // compares
    '{1'b1, OP_ZLT,     32'h0, 32'hFFFFFFFF, 32'h0, 17'h11e, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ZEQ,     32'h0, 32'h0, 32'h0, 17'h11f, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ZEQ,     32'h0, 32'hFFFFFFFF, 32'h0, 17'h120, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF, 17'h121, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_EQ,      32'h0, 32'hFFFFFFFF, 32'h0, 17'h122, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h5, 32'h5, 32'hFFFFFFFF, 17'h123, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_LT,      32'h0, 32'hFFFFFFFF, 32'h0, 17'h124, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h3, 32'h3, 32'hFFFFFFFF, 17'h125, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_GT,      32'h0, 32'h0, 32'h0, 17'h126, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h0, 32'h0, 17'h127, 5'd0, 5'd0, 32'h0, 1'b0},
    // return stack, 11 and 22 come back in lifo order
    '{1'b1, OP_DOLIT,   32'h11, 32'h11, 32'h0, 17'h128, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h22, 32'h22, 32'h11, 17'h129, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_TOR,     32'h0, 32'h11, 32'h0, 17'h12a, 5'd1, 5'd1, 32'h22, 1'b0},
    '{1'b1, OP_TOR,     32'h0, 32'h0, 32'h0, 17'h12b, 5'd0, 5'd2, 32'h11, 1'b0},
    '{1'b1, OP_RAT,     32'h0, 32'h11, 32'h0, 17'h12c, 5'd1, 5'd2, 32'h11, 1'b0},
    '{1'b1, OP_RFROM,   32'h0, 32'h11, 32'h11, 17'h12d, 5'd2, 5'd1, 32'h22, 1'b0},
    '{1'b1, OP_RFROM,   32'h0, 32'h22, 32'h11, 17'h12e, 5'd3, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h11, 32'h11, 17'h12f, 5'd2, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h11, 32'h0, 17'h130, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h0, 32'h0, 17'h131, 5'd0, 5'd0, 32'h0, 1'b0},
    // control flow, donext counts 2 1 0
    '{1'b1, OP_BRANCH,  32'h200, 32'h0, 32'h0, 17'h200, 5'd0, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h0, 32'h0, 32'h0, 17'h201, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ZBRANCH, 32'h300, 32'h0, 32'h0, 17'h300, 5'd0, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h4, 32'h4, 32'h0, 17'h301, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_ZBRANCH, 32'h400, 32'h0, 32'h0, 17'h302, 5'd0, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DOLIT,   32'h2, 32'h2, 32'h0, 17'h303, 5'd1, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_TOR,     32'h0, 32'h0, 32'h0, 17'h304, 5'd0, 5'd1, 32'h2, 1'b0},
    '{1'b1, OP_DONEXT,  32'h304, 32'h0, 32'h0, 17'h304, 5'd0, 5'd1, 32'h1, 1'b0},
    '{1'b1, OP_DONEXT,  32'h304, 32'h0, 32'h0, 17'h304, 5'd0, 5'd1, 32'h0, 1'b0},
    '{1'b1, OP_DONEXT,  32'h304, 32'h0, 32'h0, 17'h305, 5'd0, 5'd0, 32'h0, 1'b0},
    // hold rows and data stack underflow
    '{1'b0, OP_DUP,     32'h0, 32'h0, 32'h0, 17'h305, 5'd0, 5'd0, 32'h0, 1'b0},
    // nonzero tos so the underflow drop must bring back zero
    '{1'b1, OP_INVERT,  32'h0, 32'hFFFFFFFF, 32'h0, 17'h306, 5'd0, 5'd0, 32'h0, 1'b0},
    '{1'b1, OP_DROP,    32'h0, 32'h0, 32'h0, 17'h307, 5'd0, 5'd0, 32'h0, 1'b1},
    '{1'b1, OP_DOLIT,   32'h77, 32'h77, 32'h0, 17'h308, 5'd1, 5'd0, 32'h0, 1'b1},
    '{1'b0, OP_DROP,    32'h0, 32'h77, 32'h0, 17'h308, 5'd1, 5'd0, 32'h0, 1'b1},
    '{1'b0, OP_DOLIT,   32'hDEAD, 32'h77, 32'h0, 17'h308, 5'd1, 5'd0, 32'h0, 1'b1},
    '{1'b1, OP_NOP,     32'h0, 32'h77, 32'h0, 17'h309, 5'd1, 5'd0, 32'h0, 1'b1}
};

`endif

/* verif/forth_core_tb.sv */
/*
 * forth core testbench
 * steps the vector table through the core and checks the visible state per row
 */
`timescale 1ns/10ps
`default_nettype none

module forth_core_tb;
    import forth_pkg::*;

    `include "forth_vectors.svh"

    localparam int RESET_CYCLES  = 10;
    localparam int RESET_TIMEOUT = 40;            // cycles
    localparam int RUN_TIMEOUT   = N_ROWS + 40;   // cycles

    logic               clk = 1'b0;
    logic               rst;
    logic               en;
    opcode_e            op;
    logic [CELL_W-1:0]  lit;
    logic [CELL_W-1:0]  tos;
    logic [CELL_W-1:0]  nos;
    logic [CELL_W-1:0]  rs_top;
    logic [ADDR_W-1:0]  ip;
    logic [DEPTH_W-1:0] ds_depth;
    logic [DEPTH_W-1:0] rs_depth;
    logic               ds_err;
    logic               rs_err;

    int errors;
    bit table_done;   // set by the table process
    bit timed_out;

    forth_core dut_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .op       (op),
        .lit      (lit),
        .tos      (tos),
        .nos      (nos),
        .rs_top   (rs_top),
        .ip       (ip),
        .ds_depth (ds_depth),
        .rs_depth (rs_depth),
        .ds_err   (ds_err),
        .rs_err   (rs_err)
    );

    always #2 clk = ~clk;   // 4 ns period

    // the one compare point, narrower fields zero extend
    task automatic compare_value(input string name, input logic [CELL_W-1:0] expected,
                                 input logic [CELL_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic verify_reset_state();
        compare_value("reset tos", 32'h0, tos);
        compare_value("reset nos", 32'h0, nos);
        compare_value("reset ip", 32'h100, ip);
        compare_value("reset ds_depth", 32'h0, ds_depth);
        compare_value("reset rs_depth", 32'h0, rs_depth);
        compare_value("reset rs_top", 32'h0, rs_top);
        compare_value("reset ds_err", 32'h0, ds_err);
        compare_value("reset rs_err", 32'h0, rs_err);
    endtask

    task automatic expect_row(input int i);
        row_t r;
        r = VECTORS[i];
        compare_value($sformatf("row %0d tos", i), r.tos, tos);
        compare_value($sformatf("row %0d nos", i), r.nos, nos);
        compare_value($sformatf("row %0d ip", i), r.ip, ip);
        compare_value($sformatf("row %0d ds_depth", i), r.ds_depth, ds_depth);
        compare_value($sformatf("row %0d rs_depth", i), r.rs_depth, rs_depth);
        compare_value($sformatf("row %0d rs_top", i), r.rs_top, rs_top);
        compare_value($sformatf("row %0d ds_err", i), r.ds_err, ds_err);
    endtask

    // entered 1 ns past an edge, so every drive lands off the edge
    task automatic apply_table();
        for (int i = 0; i < N_ROWS; i++) begin
            en  = VECTORS[i].en;
            op  = VECTORS[i].op;
            lit = VECTORS[i].lit;
            @(posedge clk);
            #1;
            expect_row(i);   // result of the edge just passed
        end
        en         = 1'b0;
        op         = OP_NOP;
        table_done = 1'b1;
    endtask

    // reset for a fixed count of cycles, released off the edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    initial begin
        int cycles;
        en         = 1'b0;
        op         = OP_NOP;
        lit        = '0;
        errors     = 0;
        table_done = 1'b0;
        timed_out  = 1'b0;
        cycles     = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            #1;
            verify_reset_state();
            fork
                apply_table();
            join_none
            cycles = 0;
            while (!table_done && cycles < RUN_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (!table_done) begin
                $display("vector table did not complete within %0d cycles", RUN_TIMEOUT);
                timed_out = 1'b1;
                disable fork;
            end
            compare_value("rs_err", 32'h0, rs_err);   // nothing ever misused the rs
        end
        $display("errors: %0d  timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
/*
 * execution unit, decodes one opcode per enabled cycle
 * holds tos and ip, drives the data stack and owns the return stack
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input wire                             clk,
    input wire                             rst,
    input wire                             en,      // execute op this cycle
    input wire forth_pkg::opcode_e         op,
    input wire [forth_pkg::CELL_W-1:0]     lit,     // inline operand / branch target
    stack_io.master                        ds_if,   // data stack below tos
    output logic [forth_pkg::CELL_W-1:0]   tos,
    output logic [forth_pkg::ADDR_W-1:0]   ip,
    output logic [forth_pkg::CELL_W-1:0]   rs_top,
    output logic [forth_pkg::DEPTH_W-1:0]  rs_depth,
    output logic                           rs_err
);
    import forth_pkg::*;

    // everything one opcode changes
    typedef struct packed {
        logic [CELL_W-1:0] tos;
        logic [ADDR_W-1:0] ip;
        stack_cmd_e        ds_cmd;
        logic [CELL_W-1:0] ds_d;
        stack_cmd_e        rs_cmd;
        logic [CELL_W-1:0] rs_d;
    } step_t;

    logic [CELL_W-1:0] nos;    // second item, data stack top
    logic [CELL_W-1:0] rs_s;   // return stack top
    step_t             nx;

    stack_io rs_if ();

    lifo_stack rs_stack_i (
        .clk   (clk),
        .rst   (rst),
        .ss_if (rs_if.slave)
    );

    assign nos      = ds_if.s;
    assign rs_s     = rs_if.s;
    assign rs_top   = rs_if.s;
    assign rs_depth = rs_if.depth;
    assign rs_err   = rs_if.err;

    // literal and return stack transfers
    function automatic step_t flow_op(step_t st);
        case (op)
            OP_DOLIT: begin
                st.ds_cmd = SS_PUSH;    // old tos goes under
                st.tos    = lit;
            end
            OP_TOR: begin
                st.rs_cmd = SS_PUSH;    // rs_d defaults to tos
                st.ds_cmd = SS_POP;
                st.tos    = nos;
            end
            OP_RFROM: begin
                st.ds_cmd = SS_PUSH;
                st.rs_cmd = SS_POP;
                st.tos    = rs_s;
            end
            OP_RAT: begin
                st.ds_cmd = SS_PUSH;    // copy only, rs untouched
                st.tos    = rs_s;
            end
            default: ;
        endcase
        return st;
    endfunction

    // shuffles
    function automatic step_t stack_op(step_t st);
        case (op)
            OP_DUP:  st.ds_cmd = SS_PUSH;
            OP_DROP: begin
                st.ds_cmd = SS_POP;
                st.tos    = nos;        // zero if already empty
            end
            OP_OVER: begin
                st.ds_cmd = SS_PUSH;
                st.tos    = nos;
            end
            OP_SWAP: begin
                st.ds_cmd = SS_LOAD;    // tos replaces second item
                st.tos    = nos;
            end
            default: ;
        endcase
        return st;
    endfunction

    // binary ops are nos OP tos, then nos pops
    function automatic step_t alu_op(step_t st);
        case (op)
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_MAX, OP_MIN:
                st.ds_cmd = SS_POP;
            default: ;
        endcase
        case (op)
            OP_ADD:    st.tos = nos + tos;
            OP_SUB:    st.tos = nos - tos;
            OP_MUL:    st.tos = nos * tos;                    // low half only
            OP_AND:    st.tos = nos & tos;
            OP_OR:     st.tos = nos | tos;
            OP_XOR:    st.tos = nos ^ tos;
            OP_ABS:    st.tos = tos[CELL_W-1] ? -tos : tos;   // min int stays put
            OP_NEGATE: st.tos = -tos;
            OP_INVERT: st.tos = ~tos;
            OP_MAX:    st.tos = ($signed(nos) > $signed(tos)) ? nos : tos;
            OP_MIN:    st.tos = ($signed(nos) < $signed(tos)) ? nos : tos;
            default: ;
        endcase
        return st;
    endfunction

    // signed compares, flag is all ones or zero
    function automatic step_t cmp_op(step_t st);
        case (op)
            OP_ZEQ: st.tos = (tos == '0) ? TRUE_CELL : '0;
            OP_ZLT: st.tos = tos[CELL_W-1] ? TRUE_CELL : '0;
            OP_EQ: begin
                st.ds_cmd = SS_POP;
                st.tos    = (nos == tos) ? TRUE_CELL : '0;
            end
            OP_LT: begin
                st.ds_cmd = SS_POP;
                st.tos    = ($signed(nos) < $signed(tos)) ? TRUE_CELL : '0;
            end
            OP_GT: begin
                st.ds_cmd = SS_POP;
                st.tos    = ($signed(nos) > $signed(tos)) ? TRUE_CELL : '0;
            end
            default: ;
        endcase
        return st;
    endfunction

    // jumps take lit as the target
    function automatic step_t branch_op(step_t st);
        case (op)
            OP_BRANCH: st.ip = lit[ADDR_W-1:0];
            OP_ZBRANCH: begin
                st.ds_cmd = SS_POP;     // flag is consumed either way
                st.tos    = nos;
                if (tos == '0)
                    st.ip = lit[ADDR_W-1:0];
            end
            OP_DONEXT: begin
                if (rs_s != '0) begin
                    st.rs_cmd = SS_LOAD;          // count down in place
                    st.rs_d   = rs_s - 1'b1;
                    st.ip     = lit[ADDR_W-1:0];
                end else begin
                    st.rs_cmd = SS_POP;           // loop done, drop counter
                end
            end
            default: ;
        endcase
        return st;
    endfunction

    always_comb begin
        // default step, ip + 1 and no stack traffic
        nx = '{
            tos:    tos,
            ip:     ip + 1'b1,
            ds_cmd: SS_NOP,
            ds_d:   tos,
            rs_cmd: SS_NOP,
            rs_d:   tos
        };
        nx = flow_op(nx);
        nx = stack_op(nx);
        nx = alu_op(nx);
        nx = cmp_op(nx);
        nx = branch_op(nx);
    end

    // stacks move only on an enabled cycle
    assign ds_if.cmd = en ? nx.ds_cmd : SS_NOP;
    assign ds_if.d   = nx.ds_d;
    assign rs_if.cmd = en ? nx.rs_cmd : SS_NOP;
    assign rs_if.d   = nx.rs_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            tos <= '0;
            ip  <= IP_RESET;
        end else if (en) begin
            tos <= nx.tos;
            ip  <= nx.ip;
        end
    end

    // idle cycle leaves both lifos alone, seen from their depth and top
    a_idle_no_cmd: assert property (
        @(posedge clk) disable iff (rst)
        !en |=> $stable(ds_if.depth) && $stable(ds_if.s)
                && $stable(rs_if.depth) && $stable(rs_if.s)
    ) else $error("stack changed with en low");

    a_idle_ip_hold: assert property (
        @(posedge clk) disable iff (rst) !en |=> $stable(ip)
    ) else $error("ip moved with en low");

endmodule

`default_nettype wire

/* verilog/forth_core.sv */
/*
 * forth execution core top level
 * execution unit plus data stack lifo, status on plain ports
 */
`timescale 1ns/10ps
`default_nettype none

module forth_core (
    input wire                             clk,
    input wire                             rst,
    input wire                             en,        // one opcode per high cycle
    input wire forth_pkg::opcode_e         op,
    input wire [forth_pkg::CELL_W-1:0]     lit,
    output logic [forth_pkg::CELL_W-1:0]   tos,
    output logic [forth_pkg::CELL_W-1:0]   nos,       // data stack top entry
    output logic [forth_pkg::CELL_W-1:0]   rs_top,
    output logic [forth_pkg::ADDR_W-1:0]   ip,
    output logic [forth_pkg::DEPTH_W-1:0]  ds_depth,  // entries below tos
    output logic [forth_pkg::DEPTH_W-1:0]  rs_depth,
    output logic                           ds_err,
    output logic                           rs_err
);

    stack_io ds_if ();   // exec unit to data stack

    exec_unit exec_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .op       (op),
        .lit      (lit),
        .ds_if    (ds_if.master),
        .tos      (tos),
        .ip       (ip),
        .rs_top   (rs_top),
        .rs_depth (rs_depth),
        .rs_err   (rs_err)
    );

    // cells under tos
    lifo_stack ds_stack_i (
        .clk   (clk),
        .rst   (rst),
        .ss_if (ds_if.slave)
    );

    assign nos      = ds_if.s;
    assign ds_depth = ds_if.depth;
    assign ds_err   = ds_if.err;

endmodule

`default_nettype wire

/* verilog/forth_pkg.sv */
/*
 * forth core package
 * widths, reset address, stack depth and the opcode / stack command encodings
 */
`default_nettype none

package forth_pkg;

    localparam int CELL_W      = 32;                       // data cell width
    localparam int ADDR_W      = 17;                       // 128K cell address space
    localparam int STACK_DEPTH = 16;                       // entries per lifo
    localparam int DEPTH_W     = $clog2(STACK_DEPTH) + 1;  // holds 0..STACK_DEPTH

    localparam logic [ADDR_W-1:0] IP_RESET  = 'h100;       // first ip after reset
    localparam logic [CELL_W-1:0] TRUE_CELL = '1;          // forth true, false is zero

    // one executed opcode per enabled cycle
    typedef enum logic [4:0] {
        OP_NOP,
        OP_DOLIT,      // inline literal from lit port
        // stack shuffles
        OP_DUP,
        OP_DROP,
        OP_OVER,
        OP_SWAP,
        // return stack transfers
        OP_TOR,        // >r
        OP_RFROM,      // r>
        OP_RAT,        // r@
        // arithmetic and bitwise
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ABS,
        OP_NEGATE,
        OP_INVERT,
        OP_MAX,
        OP_MIN,
        // signed compares, give TRUE_CELL or 0
        OP_ZEQ,
        OP_ZLT,
        OP_EQ,
        OP_LT,
        OP_GT,
        // control flow, target in lit
        OP_BRANCH,
        OP_ZBRANCH,
        OP_DONEXT
    } opcode_e;

    // lifo command, takes effect at the next edge
    typedef enum logic [1:0] {
        SS_NOP,
        SS_PUSH,
        SS_POP,
        SS_LOAD        // overwrite top entry
    } stack_cmd_e;

endpackage

`default_nettype wire

/* verilog/lifo_stack.sv */
/*
 * register file lifo
 * push, pop and replace-top, with a depth count and sticky under/overflow flag
 */
`timescale 1ns/10ps
`default_nettype none

module lifo_stack (
    input wire       clk,
    input wire       rst,
    stack_io.slave   ss_if
);
    import forth_pkg::*;

    logic [CELL_W-1:0]  mem [STACK_DEPTH];   // entry 0 is the bottom
    logic [DEPTH_W-1:0] depth;
    logic               err;
    logic [DEPTH_W-2:0] wr_idx;              // next free slot
    logic [DEPTH_W-2:0] top_idx;             // current top slot
    logic               empty;
    logic               full;

    assign wr_idx  = depth[DEPTH_W-2:0];
    assign top_idx = depth[DEPTH_W-2:0] - 1'b1;   // wraps on empty, never read then
    assign empty   = (depth == '0);
    assign full    = (depth == DEPTH_W'(STACK_DEPTH));

    // popped value reads as zero once the stack runs dry
    assign ss_if.s     = empty ? '0 : mem[top_idx];
    assign ss_if.depth = depth;
    assign ss_if.err   = err;

    // control state, depth and sticky error
    always_ff @(posedge clk) begin
        if (rst) begin
            depth <= '0;
            err   <= 1'b0;
        end else begin
            case (ss_if.cmd)
                SS_PUSH: begin
                    if (full) err <= 1'b1;     // overflow, push dropped
                    else      depth <= depth + 1'b1;
                end
                SS_POP: begin
                    if (empty) err <= 1'b1;    // underflow
                    else       depth <= depth - 1'b1;
                end
                SS_LOAD: begin
                    if (empty) err <= 1'b1;    // nothing to overwrite
                end
                default: ;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (ss_if.cmd == SS_PUSH && !full)
            mem[wr_idx] <= ss_if.d;
        else if (ss_if.cmd == SS_LOAD && !empty)
            mem[top_idx] <= ss_if.d;            // e.g. donext countdown
    end

    a_depth_bound: assert property (
        @(posedge clk) disable iff (rst) depth <= DEPTH_W'(STACK_DEPTH)
    ) else $error("lifo depth above %0d", STACK_DEPTH);

    // err only falls through reset
    a_err_sticky: assert property (
        @(posedge clk) disable iff (rst) err |=> err
    ) else $error("lifo err cleared without reset");

endmodule

`default_nettype wire

/* verilog/stack_io.sv */
/*
 * stack port bundle
 * command and push data from the owner, top entry, depth and error back
 */
`timescale 1ns/10ps
`default_nettype none

interface stack_io;
    import forth_pkg::*;

    stack_cmd_e          cmd;     // owner command
    logic [CELL_W-1:0]   d;       // push / load data
    logic [CELL_W-1:0]   s;       // top stored entry, zero when empty
    logic [DEPTH_W-1:0]  depth;   // stored entries
    logic                err;     // sticky under/overflow

    // owner side
    modport master (
        output cmd,
        output d,
        input  s,
        input  depth,
        input  err
    );

    // lifo side
    modport slave (
        input  cmd,
        input  d,
        output s,
        output depth,
        output err
    );

endinterface

`default_nettype wire
